//--- src/dcache_pkg.sv
package dcache_pkg;

    localparam int NUM_WAYS       = 4;
    localparam int NUM_SETS       = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_W       = 4;   // byte offset within a line
    localparam int INDEX_W        = 4;
    localparam int TAG_W          = 24;

    typedef logic [31:0]                  addr_t;
    typedef logic [31:0]                  word_t;
    typedef logic [3:0]                   strb_t;
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;  // word 0 in the low bits
    typedef logic [TAG_W-1:0]             tag_t;
    typedef logic [INDEX_W-1:0]           index_t;
    typedef logic [1:0]                   way_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        EVICT,
        WB_WAIT,
        REFILL_REQ,
        REFILL,
        INSTALL,
        RESPOND
    } ctrl_state_e;

    // replace the strobed bytes of a word
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

//--- src/tag_store.sv
`timescale 1ns/1ns

module tag_store (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              lookup_en,
    input  dcache_pkg::addr_t rd_addr,
    input  dcache_pkg::addr_t req_addr,
    input  logic              tag_we,
    input  logic              dirty_set,
    input  dcache_pkg::way_t  access_way,
    output logic              hit,
    output dcache_pkg::way_t  hit_way,
    output dcache_pkg::way_t  victim_way,
    output logic              victim_valid,
    output logic              victim_dirty,
    output dcache_pkg::tag_t  victim_tag
);
    import dcache_pkg::*;

    tag_t                tags       [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_bits [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_bits [NUM_SETS];
    logic [1:0]          age        [NUM_SETS][NUM_WAYS];  // 0 is youngest

    tag_t                tag_q [NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q, dirty_q, match;
    logic                lookup_q, lru_touch;
    index_t              rd_idx, req_idx;
    tag_t                req_tag;

    assign rd_idx  = rd_addr[OFFSET_W +: INDEX_W];
    assign req_idx = req_addr[OFFSET_W +: INDEX_W];
    assign req_tag = req_addr[31 -: TAG_W];

    // set read, compared one cycle later
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            tag_q   <= tags[rd_idx];
            valid_q <= valid_bits[rd_idx];
            dirty_q <= dirty_bits[rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= lookup_en;
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = valid_q[w] && (tag_q[w] == req_tag);
            if (match[w]) hit_way = way_t'(w);
        end
        hit = |match;
    end

    // lowest invalid way wins, otherwise the oldest
    always_comb begin
        victim_way = '0;
        for (int w = NUM_WAYS-1; w >= 0; w--) begin
            if (age[req_idx][w] == 2'(NUM_WAYS-1)) victim_way = way_t'(w);
        end
        for (int w = NUM_WAYS-1; w >= 0; w--) begin
            if (!valid_q[w]) victim_way = way_t'(w);
        end
    end

    assign victim_valid = valid_q[victim_way];
    assign victim_dirty = dirty_q[victim_way];
    assign victim_tag   = tag_q[victim_way];

    always_ff @(posedge clk) begin
        if (tag_we) tags[req_idx][access_way] <= req_tag;
    end

    assign lru_touch = (lookup_q && hit) || tag_we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_bits[s] <= '0;
                dirty_bits[s] <= '0;
                for (int w = 0; w < NUM_WAYS; w++) age[s][w] <= 2'(w);
            end
        end else begin
            if (tag_we) begin
                valid_bits[req_idx][access_way] <= 1'b1;
                dirty_bits[req_idx][access_way] <= dirty_set;  // clean unless a write miss
            end else if (dirty_set) begin
                dirty_bits[req_idx][access_way] <= 1'b1;
            end
            if (lru_touch) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    if (way_t'(w) == access_way) begin
                        age[req_idx][w] <= '0;
                    end else if (age[req_idx][w] < age[req_idx][access_way]) begin
                        age[req_idx][w] <= age[req_idx][w] + 2'd1;
                    end
                end
            end
        end
    end

endmodule

//--- src/data_store.sv
`timescale 1ns/1ns

module data_store (
    input  logic              clk,
    input  dcache_pkg::addr_t rd_addr,
    input  dcache_pkg::addr_t req_addr,
    input  logic              rd_en,
    input  logic              data_we,
    input  dcache_pkg::strb_t data_strb,
    input  logic              data_line_we,
    input  dcache_pkg::way_t  access_way,
    input  dcache_pkg::word_t wr_word,
    input  dcache_pkg::line_t wr_line,
    output dcache_pkg::line_t rd_lines [dcache_pkg::NUM_WAYS]
);
    import dcache_pkg::*;

    line_t      mem [NUM_WAYS][NUM_SETS];
    index_t     rd_idx, wr_idx;
    logic [1:0] word_sel;

    assign rd_idx   = rd_addr[OFFSET_W +: INDEX_W];
    assign wr_idx   = req_addr[OFFSET_W +: INDEX_W];
    assign word_sel = req_addr[OFFSET_W-1:2];

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < NUM_WAYS; w++) rd_lines[w] <= mem[w][rd_idx];  // all ways at once
        end
        if (data_line_we) begin
            mem[access_way][wr_idx] <= wr_line;
        end else if (data_we) begin
            mem[access_way][wr_idx][word_sel*32 +: 32] <=
                merge_bytes(mem[access_way][wr_idx][word_sel*32 +: 32], wr_word, data_strb);
        end
    end

endmodule

//--- src/refill_buffer.sv
`timescale 1ns/1ns

module refill_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  refill_start,
    input  dcache_pkg::addr_t     req_addr,
    input  dcache_pkg::cache_op_e req_op,
    input  dcache_pkg::strb_t     req_strb,
    input  dcache_pkg::word_t     req_wdata,
    input  logic                  ret_valid,
    input  logic                  ret_last,
    input  dcache_pkg::word_t     ret_data,
    output logic                  r_data_ready,
    output logic                  fill_done,
    output dcache_pkg::line_t     fill_line
);
    import dcache_pkg::*;

    logic [1:0] beat;      // word slot of the next beat
    logic       take;
    word_t      merged;

    assign take      = ret_valid && r_data_ready;
    assign fill_done = take && ret_last;

    // pending store lands on its own word
    always_comb begin
        merged = ret_data;
        if (req_op == OP_WRITE && beat == req_addr[OFFSET_W-1:2]) begin
            merged = merge_bytes(ret_data, req_wdata, req_strb);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_data_ready <= 1'b0;
            beat         <= '0;
        end else if (refill_start) begin
            r_data_ready <= 1'b1;
            beat         <= '0;
        end else if (take) begin
            beat <= beat + 2'd1;
            if (ret_last) r_data_ready <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) fill_line[beat*32 +: 32] <= merged;
    end

endmodule

//--- src/writeback_buffer.sv
`timescale 1ns/1ns

module writeback_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_load,
    input  dcache_pkg::addr_t wb_addr,
    input  dcache_pkg::line_t victim_line,
    output logic              w_req,
    output dcache_pkg::addr_t w_addr,
    input  logic              w_rdy,
    output logic              w_data_req,
    input  logic              w_data_ready,
    output logic              w_last,
    output dcache_pkg::strb_t w_strb,
    output dcache_pkg::word_t w_data_bus,
    output logic              b_ready,
    input  logic              b_valid,
    output logic              wb_done
);
    import dcache_pkg::*;

    line_t      line_q;
    logic [1:0] beat;

    // victim copy, held until the burst is out
    always_ff @(posedge clk) begin
        if (wb_load) begin
            line_q <= victim_line;
            w_addr <= wb_addr;
        end
    end

    // the three phase flags double as the sequencer state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_req      <= 1'b0;
            w_data_req <= 1'b0;
            b_ready    <= 1'b0;
            beat       <= '0;
        end else begin
            if (wb_load) begin
                w_req <= 1'b1;
            end else if (w_req && w_rdy) begin
                w_req      <= 1'b0;
                w_data_req <= 1'b1;
                beat       <= '0;
            end else if (w_data_req && w_data_ready) begin
                beat <= beat + 2'd1;
                if (w_last) begin
                    w_data_req <= 1'b0;
                    b_ready    <= 1'b1;
                end
            end else if (b_ready && b_valid) begin
                b_ready <= 1'b0;
            end
        end
    end

    assign w_last     = w_data_req && (beat == 2'(WORDS_PER_LINE-1));
    assign w_strb     = '1;   // full words only
    assign w_data_bus = line_q[beat*32 +: 32];
    assign wb_done    = b_ready && b_valid;

endmodule

//--- src/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid,
    input  dcache_pkg::cache_op_e op,
    input  dcache_pkg::addr_t     addr,
    input  dcache_pkg::strb_t     write_type,
    input  dcache_pkg::word_t     w_data,
    input  logic                  hit,
    input  dcache_pkg::way_t      hit_way,
    input  dcache_pkg::way_t      victim_way,
    input  logic                  victim_valid,
    input  logic                  victim_dirty,
    input  dcache_pkg::tag_t      victim_tag,
    input  logic                  fill_done,
    input  logic                  wb_done,
    input  logic                  r_rdy,
    input  dcache_pkg::line_t     rd_lines [dcache_pkg::NUM_WAYS],
    input  dcache_pkg::line_t     fill_line,
    output dcache_pkg::addr_t     req_addr,
    output dcache_pkg::cache_op_e req_op,
    output dcache_pkg::strb_t     req_strb,
    output dcache_pkg::word_t     req_wdata,
    output logic                  data_valid,
    output dcache_pkg::word_t     r_data,
    output logic                  lookup_en,
    output logic                  tag_we,
    output logic                  dirty_set,
    output logic                  data_we,
    output dcache_pkg::strb_t     data_strb,
    output logic                  data_line_we,
    output dcache_pkg::way_t      access_way,
    output logic                  refill_start,
    output logic                  wb_load,
    output dcache_pkg::addr_t     wb_addr,
    output dcache_pkg::line_t     victim_line,
    output logic                  r_req,
    output dcache_pkg::addr_t     r_addr
);
    import dcache_pkg::*;

    ctrl_state_e state, state_next;
    way_t        victim_way_q;
    tag_t        victim_tag_q;
    logic [1:0]  word_sel;
    logic        write_hit;
    line_t       resp_line;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // request register, loaded when the lookup starts
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            req_addr  <= addr;
            req_op    <= op;
            req_strb  <= write_type;
            req_wdata <= w_data;
        end
        if (state == LOOKUP && !hit) begin
            victim_way_q <= victim_way;
            victim_tag_q <= victim_tag;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:       if (valid) state_next = LOOKUP;
            LOOKUP: begin
                if (hit) begin
                    state_next = IDLE;
                end else if (victim_valid && victim_dirty) begin
                    state_next = EVICT;
                end else begin
                    state_next = REFILL_REQ;
                end
            end
            EVICT:      state_next = WB_WAIT;   // line copied in one cycle
            WB_WAIT:    if (wb_done) state_next = REFILL_REQ;
            REFILL_REQ: if (r_rdy) state_next = REFILL;
            REFILL:     if (fill_done) state_next = INSTALL;
            INSTALL:    state_next = RESPOND;
            RESPOND:    state_next = IDLE;
            default:    state_next = IDLE;
        endcase
    end

    assign write_hit    = (state == LOOKUP) && hit && (req_op == OP_WRITE);
    assign lookup_en    = (state == IDLE) && valid;
    assign data_valid   = ((state == LOOKUP) && hit) || (state == RESPOND);
    assign data_we      = write_hit;
    assign data_strb    = req_strb;
    assign tag_we       = (state == INSTALL);
    assign data_line_we = (state == INSTALL);
    assign dirty_set    = write_hit || ((state == INSTALL) && (req_op == OP_WRITE));
    assign access_way   = (state == LOOKUP) ? hit_way : victim_way_q;
    assign refill_start = (state == REFILL_REQ) && r_rdy;
    assign wb_load      = (state == EVICT);
    assign r_req        = (state == REFILL_REQ);

    assign r_addr      = {req_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
    assign wb_addr     = {victim_tag_q, req_addr[OFFSET_W +: INDEX_W], {OFFSET_W{1'b0}}};
    assign victim_line = rd_lines[victim_way_q];  // array output held since the lookup

    // hit data from the arrays, miss data from the merged refill line
    assign word_sel  = req_addr[OFFSET_W-1:2];
    assign resp_line = (state == RESPOND) ? fill_line : rd_lines[hit_way];
    assign r_data    = resp_line[word_sel*32 +: 32];

endmodule

//--- src/dcache.sv
`timescale 1ns/1ns

module dcache (
    input  logic                  clk,
    input  logic                  rst_n,
    // cpu side
    input  logic                  valid,
    input  dcache_pkg::cache_op_e op,
    input  dcache_pkg::addr_t     addr,
    input  dcache_pkg::strb_t     write_type,
    input  dcache_pkg::word_t     w_data,
    output logic                  data_valid,
    output dcache_pkg::word_t     r_data,
    // read bus
    output logic                  r_req,
    output dcache_pkg::addr_t     r_addr,
    input  logic                  r_rdy,
    output logic                  r_data_ready,
    input  logic                  ret_valid,
    input  logic                  ret_last,
    input  dcache_pkg::word_t     ret_data,
    // write bus
    output logic                  w_req,
    output dcache_pkg::addr_t     w_addr,
    input  logic                  w_rdy,
    output logic                  w_data_req,
    input  logic                  w_data_ready,
    output logic                  w_last,
    output dcache_pkg::strb_t     w_strb,
    output dcache_pkg::word_t     w_data_bus,
    output logic                  b_ready,
    input  logic                  b_valid
);
    import dcache_pkg::*;

    addr_t     req_addr, wb_addr;
    cache_op_e req_op;
    strb_t     req_strb, data_strb;
    word_t     req_wdata;
    logic      lookup_en, tag_we, dirty_set, data_we, data_line_we;
    logic      refill_start, wb_load, fill_done, wb_done;
    logic      hit, victim_valid, victim_dirty;
    way_t      access_way, hit_way, victim_way;
    tag_t      victim_tag;
    line_t     rd_lines [NUM_WAYS];
    line_t     fill_line, victim_line;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid        (valid),
        .op           (op),
        .addr         (addr),
        .write_type   (write_type),
        .w_data       (w_data),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .fill_done    (fill_done),
        .wb_done      (wb_done),
        .r_rdy        (r_rdy),
        .rd_lines     (rd_lines),
        .fill_line    (fill_line),
        .req_addr     (req_addr),
        .req_op       (req_op),
        .req_strb     (req_strb),
        .req_wdata    (req_wdata),
        .data_valid   (data_valid),
        .r_data       (r_data),
        .lookup_en    (lookup_en),
        .tag_we       (tag_we),
        .dirty_set    (dirty_set),
        .data_we      (data_we),
        .data_strb    (data_strb),
        .data_line_we (data_line_we),
        .access_way   (access_way),
        .refill_start (refill_start),
        .wb_load      (wb_load),
        .wb_addr      (wb_addr),
        .victim_line  (victim_line),
        .r_req        (r_req),
        .r_addr       (r_addr)
    );

    tag_store u_tags (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_en    (lookup_en),
        .rd_addr      (addr),
        .req_addr     (req_addr),
        .tag_we       (tag_we),
        .dirty_set    (dirty_set),
        .access_way   (access_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    data_store u_data (
        .clk          (clk),
        .rd_addr      (addr),
        .req_addr     (req_addr),
        .rd_en        (lookup_en),
        .data_we      (data_we),
        .data_strb    (data_strb),
        .data_line_we (data_line_we),
        .access_way   (access_way),
        .wr_word      (req_wdata),
        .wr_line      (fill_line),
        .rd_lines     (rd_lines)
    );

    refill_buffer u_refill (
        .clk          (clk),
        .rst_n        (rst_n),
        .refill_start (refill_start),
        .req_addr     (req_addr),
        .req_op       (req_op),
        .req_strb     (req_strb),
        .req_wdata    (req_wdata),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .ret_data     (ret_data),
        .r_data_ready (r_data_ready),
        .fill_done    (fill_done),
        .fill_line    (fill_line)
    );

    writeback_buffer u_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_load      (wb_load),
        .wb_addr      (wb_addr),
        .victim_line  (victim_line),
        .w_req        (w_req),
        .w_addr       (w_addr),
        .w_rdy        (w_rdy),
        .w_data_req   (w_data_req),
        .w_data_ready (w_data_ready),
        .w_last       (w_last),
        .w_strb       (w_strb),
        .w_data_bus   (w_data_bus),
        .b_ready      (b_ready),
        .b_valid      (b_valid),
        .wb_done      (wb_done)
    );

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ns

// free-running clock, 20 ns period
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

//--- tb/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;
    import dcache_pkg::*;

    logic      clk, rst_n;
    logic      valid, data_valid;
    cache_op_e op;
    addr_t     addr, r_addr, w_addr;
    strb_t     write_type, w_strb;
    word_t     w_data, r_data, ret_data, w_data_bus;
    logic      r_req, r_rdy, r_data_ready, ret_valid, ret_last;
    logic      w_req, w_rdy, w_data_req, w_data_ready, w_last, b_ready, b_valid;

    word_t mem_model [addr_t];   // bus side memory, sparse
    word_t shadow    [addr_t];   // what the cpu should read back
    word_t wb_words  [4];        // last write burst seen
    addr_t last_r_addr, last_w_addr;
    int    read_bursts  = 0;
    int    write_bursts = 0;
    int    errors       = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    bit    hung         = 1'b0;

    tb_clock clk_gen (.clk(clk));

    dcache dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid        (valid),
        .op           (op),
        .addr         (addr),
        .write_type   (write_type),
        .w_data       (w_data),
        .data_valid   (data_valid),
        .r_data       (r_data),
        .r_req        (r_req),
        .r_addr       (r_addr),
        .r_rdy        (r_rdy),
        .r_data_ready (r_data_ready),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .ret_data     (ret_data),
        .w_req        (w_req),
        .w_addr       (w_addr),
        .w_rdy        (w_rdy),
        .w_data_req   (w_data_req),
        .w_data_ready (w_data_ready),
        .w_last       (w_last),
        .w_strb       (w_strb),
        .w_data_bus   (w_data_bus),
        .b_ready      (b_ready),
        .b_valid      (b_valid)
    );

    // untouched words read back as their own address
    function automatic word_t mem_word(input addr_t a);
        return mem_model.exists(a) ? mem_model[a] : a;
    endfunction

    function automatic word_t expect_word(input addr_t a);
        return shadow.exists(a) ? shadow[a] : a;
    endfunction

    function automatic word_t strobe_merge(input word_t old_w, input word_t new_w, input strb_t s);
        word_t mask;
        mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic addr_t evict_line(input int k);
        return {24'h000500 + 24'(k), 4'h9, 4'h0};   // all in set 9
    endfunction

    // 1 if any request output is not a clean zero
    function automatic int outputs_not_idle();
        return ({data_valid, r_req, r_data_ready, w_req, w_data_req, w_last, b_ready}
                === 7'b0) ? 0 : 1;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("ERROR t=%0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // one request, waits for data_valid
    task automatic cpu_access(input cache_op_e o, input addr_t a, input strb_t s,
                              input word_t d, output word_t rd);
        int n;
        rd = '0;
        if (hung) return;
        @(posedge clk);
        valid      <= 1'b1;
        op         <= o;
        addr       <= a;
        write_type <= s;
        w_data     <= d;
        @(posedge clk);   // sampled in IDLE here
        valid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!data_valid && n < 200);
        if (!data_valid) begin
            errors++;
            hung = 1'b1;
            $display("timeout: %s at %h got no data_valid within 200 cycles", o.name(), a);
        end else begin
            rd = r_data;
            if (o == OP_WRITE) shadow[a] = strobe_merge(expect_word(a), d, s);
        end
    endtask

    task automatic read_check(input addr_t a, input string name);
        word_t rd;
        cpu_access(OP_READ, a, 4'h0, '0, rd);
        if (!hung) check_word(name, rd, expect_word(a));
    endtask

    task automatic write_word(input addr_t a, input strb_t s, input word_t d);
        word_t rd;
        cpu_access(OP_WRITE, a, s, d, rd);
    endtask

    // read channel: random r_rdy delay, then four beats with random gaps
    task automatic read_responder();
        addr_t base;
        forever begin
            @(negedge clk);
            if (r_req) begin
                read_bursts++;
                base        = r_addr;
                last_r_addr = base;
                repeat ($urandom_range(3, 0)) @(posedge clk);
                @(posedge clk);
                r_rdy <= 1'b1;
                @(posedge clk);
                r_rdy <= 1'b0;
                for (int i = 0; i < 4; i++) begin
                    repeat ($urandom_range(3, 0)) begin
                        @(posedge clk);
                        ret_valid <= 1'b0;
                    end
                    @(posedge clk);
                    ret_valid <= 1'b1;
                    ret_last  <= (i == 3);
                    ret_data  <= mem_word(base + 4 * i);
                    @(negedge clk);
                    check_count("r_data_ready on read beat", int'(r_data_ready), 1);
                end
                @(posedge clk);
                ret_valid <= 1'b0;
                ret_last  <= 1'b0;
            end
        end
    endtask

    // write channel: address, four data beats, then the response
    task automatic write_responder();
        addr_t base;
        forever begin
            @(negedge clk);
            if (w_req) begin
                write_bursts++;
                base        = w_addr;
                last_w_addr = base;
                repeat ($urandom_range(3, 0)) @(posedge clk);
                @(posedge clk);
                w_rdy <= 1'b1;
                @(posedge clk);
                w_rdy <= 1'b0;
                for (int i = 0; i < 4; i++) begin
                    repeat ($urandom_range(3, 0)) @(posedge clk);
                    @(posedge clk);
                    w_data_ready <= 1'b1;
                    @(negedge clk);
                    check_count("w_data_req on write beat", int'(w_data_req), 1);
                    check_count("w_last on write beat", int'(w_last), int'(i == 3));
                    check_count("w_strb on write beat", int'(w_strb), 15);
                    wb_words[i]             = w_data_bus;
                    mem_model[base + 4 * i] = w_data_bus;
                    @(posedge clk);
                    w_data_ready <= 1'b0;
                end
                repeat ($urandom_range(3, 0)) @(posedge clk);
                @(posedge clk);
                b_valid <= 1'b1;
                @(negedge clk);
                check_count("b_ready on write response", int'(b_ready), 1);
                @(posedge clk);
                b_valid <= 1'b0;
            end
        end
    endtask

    task automatic test_reset_state();
        int    e0, rb;
        addr_t a;
        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i == 15) rst_n <= 1'b1;
            @(negedge clk);
            check_count("request outputs during reset", outputs_not_idle(), 0);
        end
        repeat (3) begin
            @(negedge clk);
            check_count("request outputs after reset", outputs_not_idle(), 0);
        end
        a      = $urandom();
        a[7:4] = 4'h2;   // keep clear of the other tests' sets
        a[1:0] = 2'b00;
        rb     = read_bursts;
        read_check(a, "first read data");
        check_count("first read misses", read_bursts - rb, 1);
        report_test("reset_state", e0);
    endtask

    task automatic test_read_miss();
        int e0, rb, wb;
        e0 = errors;
        rb = read_bursts;
        wb = write_bursts;
        read_check(32'h0001_2354, "read miss data");
        check_count("read miss read bursts", read_bursts - rb, 1);
        check_count("read miss write bursts", write_bursts - wb, 0);
        check_addr("read miss burst address", last_r_addr, 32'h0001_2350);
        report_test("read_miss", e0);
    endtask

    task automatic test_read_hit();
        int e0, rb, wb;
        e0 = errors;
        rb = read_bursts;
        wb = write_bursts;
        for (int w = 0; w < 4; w++) read_check(32'h0001_2350 + 4 * w, "read hit data");
        check_count("read hit bus traffic", (read_bursts - rb) + (write_bursts - wb), 0);
        report_test("read_hit", e0);
    endtask

    task automatic test_write_hit();
        int e0, rb, wb;
        e0 = errors;
        rb = read_bursts;
        wb = write_bursts;
        write_word(32'h0001_2358, 4'b0101, 32'haabb_ccdd);
        read_check(32'h0001_2358, "write hit merged word");
        check_count("write hit bus traffic", (read_bursts - rb) + (write_bursts - wb), 0);
        report_test("write_hit", e0);
    endtask

    task automatic test_write_miss();
        int e0, rb, wb;
        e0 = errors;
        rb = read_bursts;
        wb = write_bursts;
        write_word(32'h0003_4568, 4'b1100, 32'h1122_3344);
        check_count("write miss read bursts", read_bursts - rb, 1);
        check_count("write miss write bursts", write_bursts - wb, 0);
        check_addr("write miss burst address", last_r_addr, 32'h0003_4560);
        read_check(32'h0003_4568, "write miss merged word");
        check_count("write miss reread bursts", read_bursts - rb, 1);
        report_test("write_miss", e0);
    endtask

    task automatic test_dirty_evict();
        int e0, rb, wb;
        int touch [4];
        e0    = errors;
        touch = '{1, 0, 2, 3};   // leaves line 1 oldest
        for (int k = 0; k < 4; k++) read_check(evict_line(k), "evict fill data");
        write_word(evict_line(1) + 4, 4'b0011, 32'hcafe_f00d);
        write_word(evict_line(3) + 8, 4'b1111, 32'h1234_5678);
        for (int k = 0; k < 4; k++) read_check(evict_line(touch[k]), "evict touch data");
        rb = read_bursts;
        wb = write_bursts;
        read_check(evict_line(4) + 12, "evict new line data");
        check_count("dirty victim write bursts", write_bursts - wb, 1);
        check_count("dirty victim read bursts", read_bursts - rb, 1);
        check_addr("write-back address", last_w_addr, evict_line(1));
        for (int i = 0; i < 4; i++) begin
            check_word("write-back data", wb_words[i], expect_word(evict_line(1) + 4 * i));
        end
        // line 0 is now oldest and clean
        wb = write_bursts;
        read_check(evict_line(5), "clean victim data");
        check_count("clean victim write bursts", write_bursts - wb, 0);
        read_check(evict_line(1) + 4, "written-back word reread");
        report_test("dirty_evict", e0);
    endtask

    initial begin
        void'($urandom(71));
        rst_n        = 1'b0;
        valid        = 1'b0;
        op           = OP_READ;
        addr         = '0;
        write_type   = '0;
        w_data       = '0;
        r_rdy        = 1'b0;
        ret_valid    = 1'b0;
        ret_last     = 1'b0;
        ret_data     = '0;
        w_rdy        = 1'b0;
        w_data_ready = 1'b0;
        b_valid      = 1'b0;
        fork
            read_responder();
            write_responder();
        join_none
        test_reset_state();
        if (!hung) test_read_miss();
        if (!hung) test_read_hit();
        if (!hung) test_write_hit();
        if (!hung) test_write_miss();
        if (!hung) test_dirty_evict();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- dcache.f
src/dcache_pkg.sv
src/tag_store.sv
src/data_store.sv
src/refill_buffer.sv
src/writeback_buffer.sv
src/dcache_ctrl.sv
src/dcache.sv
tb/tb_clock.sv
tb/dcache_tb.sv
